//--- verilog/osc_test_cfg.svh
`ifndef OSC_TEST_CFG_SVH
`define OSC_TEST_CFG_SVH

//////////////////////////////
// Oscillator
//////////////////////////////

// Phase accumulator width, one full wrap is 2**width cycles at k = 1
`define OSC_ACCUM_WIDTH 12

// Increment from switches 8:0
`define OSC_K_WIDTH 9

//////////////////////////////
// Frequency meter
//////////////////////////////

// Gate window, same as one accumulator wrap so count reads back as k
`define OSC_GATE_CYCLES 4096

`define OSC_COUNT_WIDTH 16 // Result register width

//////////////////////////////
// Display
//////////////////////////////

`define DISP_SCAN_DIV 16 // Clock cycles each digit stays lit

`define DISP_DIGITS 8 // Digits on the board

`endif

//--- verilog/osc_pkg.sv
package osc_pkg;

`include "osc_test_cfg.svh"

    //////////////////////////////
    // NCO side
    //////////////////////////////

    // Running phase, MSB is the test wave
    typedef logic [`OSC_ACCUM_WIDTH-1:0] phase_t;

    // Phase step per enabled cycle
    typedef logic [`OSC_K_WIDTH-1:0] k_val_t;

    //////////////////////////////
    // Measurement side
    //////////////////////////////

    // Edges counted in one gate window
    typedef logic [`OSC_COUNT_WIDTH-1:0] freq_count_t;

    // Position inside the gate window, wraps once per window
    typedef logic [$clog2(`OSC_GATE_CYCLES)-1:0] gate_cnt_t;

endpackage

//--- verilog/disp_pkg.sv
package disp_pkg;

`include "osc_test_cfg.svh"

    // Which digit is being driven
    typedef logic [$clog2(`DISP_DIGITS)-1:0] digit_idx_t;

    // Active low, bit 0 = a ... bit 6 = g, bit 7 = point
    typedef logic [7:0] segments_t;

    // One hex nibble per digit
    typedef logic [4*`DISP_DIGITS-1:0] disp_value_t;

    //////////////////////////////
    // Hex glyph lookup
    //////////////////////////////

    // Returns the active-low glyph, point dark
    function automatic segments_t hex_to_seg(input logic [3:0] nibble);
        logic [6:0] lit; // Active-high gfedcba
        case (nibble)
            4'h0:    lit = 7'h3f;
            4'h1:    lit = 7'h06;
            4'h2:    lit = 7'h5b;
            4'h3:    lit = 7'h4f;
            4'h4:    lit = 7'h66;
            4'h5:    lit = 7'h6d;
            4'h6:    lit = 7'h7d;
            4'h7:    lit = 7'h07;
            4'h8:    lit = 7'h7f;
            4'h9:    lit = 7'h6f;
            4'ha:    lit = 7'h77; // A
            4'hb:    lit = 7'h7c; // Lower case b
            4'hc:    lit = 7'h39; // C
            4'hd:    lit = 7'h5e; // Lower case d
            4'he:    lit = 7'h79; // E
            default: lit = 7'h71; // F
        endcase
        return {1'b1, ~lit}; // Invert for common-anode drive
    endfunction

endpackage

//--- verilog/phase_accum.sv
`timescale 1ns/1ps

`include "osc_test_cfg.svh"

// NCO, output frequency = k * f_clk / 2**OSC_ACCUM_WIDTH
module phase_accum
    import osc_pkg::*;
(
    input  logic   fpga_clk_i, // System clock
    input  logic   rst_n_i,    // Sync reset, active low
    input  logic   enable_i,   // Switch 9
    input  k_val_t k_val_i,    // Switches 8:0
    output logic   wave_o      // Square wave, duty near half
);

    phase_t accum_q;
    logic   wave_q;

    //////////////////////////////
    // Accumulator
    //////////////////////////////

    always_ff @(posedge fpga_clk_i) begin
        if (!rst_n_i) begin
            accum_q <= '0;
        end else if (enable_i) begin
            // Wraps modulo 2**width, carry dropped
            accum_q <= accum_q + phase_t'(k_val_i);
        end
        // Disabled: phase frozen, wave stays put
    end

    //////////////////////////////
    // Output wave
    //////////////////////////////

    // MSB taken one stage later so the pin sees a clean register
    always_ff @(posedge fpga_clk_i) begin
        if (!rst_n_i) begin
            wave_q <= 1'b0;
        end else begin
            wave_q <= accum_q[`OSC_ACCUM_WIDTH-1];
        end
    end

    assign wave_o = wave_q;

endmodule

//--- verilog/freq_meter.sv
`timescale 1ns/1ps

`include "osc_test_cfg.svh"

// Gated edge counter over a fixed window
module freq_meter
    import osc_pkg::*;
(
    input  logic        fpga_clk_i,
    input  logic        rst_n_i,
    input  logic        wave_i,  // Test wave, plain data here
    output freq_count_t count_o, // Edges in last full window
    output logic        valid_o  // One-cycle strobe per window
);

    localparam gate_cnt_t GATE_LAST = gate_cnt_t'(`OSC_GATE_CYCLES - 1);

    logic        wave_s;    // Current sample
    logic        wave_d;    // Previous sample
    logic        rise;
    gate_cnt_t   gate_q;
    logic        gate_end;
    freq_count_t edge_cnt_q;
    freq_count_t edge_next;
    freq_count_t count_q;
    logic        valid_q;

    //////////////////////////////
    // Edge detect
    //////////////////////////////

    always_ff @(posedge fpga_clk_i) begin
        if (!rst_n_i) begin
            wave_s <= 1'b0;
            wave_d <= 1'b0;
        end else begin
            wave_s <= wave_i; // Single sampling stage
            wave_d <= wave_s;
        end
    end

    assign rise = wave_s & ~wave_d;

    // Running total with this cycle's edge, stuck at all ones
    assign edge_next = (rise && edge_cnt_q != '1) ? edge_cnt_q + 1'b1 : edge_cnt_q;

    assign gate_end = (gate_q == GATE_LAST);

    //////////////////////////////
    // Gate and result
    //////////////////////////////

    always_ff @(posedge fpga_clk_i) begin
        if (!rst_n_i) begin
            gate_q     <= '0;
            edge_cnt_q <= '0;
            count_q    <= '0;
            valid_q    <= 1'b0;
        end else begin
            valid_q <= gate_end;
            if (gate_end) begin
                gate_q     <= '0;
                count_q    <= edge_next; // Includes an edge on the last cycle
                edge_cnt_q <= '0;        // Fresh window
            end else begin
                gate_q     <= gate_q + 1'b1;
                edge_cnt_q <= edge_next;
            end
        end
    end

    // Strobe and result appear together, first gate cycle of the next window
    assign count_o = count_q;
    assign valid_o = valid_q;

endmodule

//--- verilog/seven_seg_driver.sv
`timescale 1ns/1ps

`include "osc_test_cfg.svh"

// Multiplexed hex display, one digit lit at a time
module seven_seg_driver
    import disp_pkg::*;
(
    input  logic                    fpga_clk_i,
    input  logic                    rst_n_i,
    input  disp_value_t             value_i,   // Nibble n shown on digit n
    output logic [`DISP_DIGITS-1:0] digit_o,   // Active-low digit enables
    output segments_t               segment_o  // Active-low segments
);

    localparam int DIV_W = $clog2(`DISP_SCAN_DIV);
    localparam logic [DIV_W-1:0] DIV_LAST = DIV_W'(`DISP_SCAN_DIV - 1);
    localparam digit_idx_t IDX_LAST = digit_idx_t'(`DISP_DIGITS - 1);
    localparam digit_idx_t POINT_DIGIT = digit_idx_t'(4); // Separator position

    logic [DIV_W-1:0] div_q;
    digit_idx_t       idx_q;
    logic [3:0]       nibble;
    segments_t        glyph;

    //////////////////////////////
    // Scan timing
    //////////////////////////////

    always_ff @(posedge fpga_clk_i) begin
        if (!rst_n_i) begin
            div_q <= '0;
            idx_q <= '0;
        end else begin
            if (div_q == DIV_LAST) begin
                div_q <= '0;
                // Next digit, back to 0 after the last
                idx_q <= (idx_q == IDX_LAST) ? '0 : idx_q + 1'b1;
            end else begin
                div_q <= div_q + 1'b1;
            end
        end
    end

    //////////////////////////////
    // Digit and segment drive
    //////////////////////////////

    // Low bit at the index, all dark while reset held
    always_comb begin
        digit_o = '1;
        if (rst_n_i) begin
            digit_o[idx_q] = 1'b0;
        end
    end

    // Live value, so a new count shows up right away
    assign nibble = value_i[idx_q*4 +: 4];
    assign glyph  = hex_to_seg(nibble);

    always_comb begin
        segment_o = glyph;
        if (idx_q == POINT_DIGIT) begin
            segment_o[7] = 1'b0; // Point between count and switches
        end
    end

endmodule

//--- verilog/osc_test_top.sv
`timescale 1ns/1ps

`include "osc_test_cfg.svh"

// Oscillator test board top, NCO + meter + display
module osc_test_top
    import osc_pkg::*;
    import disp_pkg::*;
(
    input  logic                    fpga_clk_i,   // Single board clock
    input  logic                    rst_n_i,      // Sync reset, active low
    input  logic [15:0]             switches_i,
    output logic                    clk_pa_o,     // NCO wave to a test pin
    output freq_count_t             freq_count_o,
    output logic                    freq_valid_o,
    output logic [`DISP_DIGITS-1:0] digit_o,
    output segments_t               segment_o
);

    logic        enable_pa_x;
    k_val_t      k_val_pa_x;
    logic        clk_pa_x;
    freq_count_t count_x;
    logic        valid_x;
    disp_value_t disp_val_x;

    // Switch map, 15:10 go to the display only
    assign enable_pa_x = switches_i[9];
    assign k_val_pa_x  = switches_i[8:0];

    // Count on the left four digits, raw switches on the right
    assign disp_val_x = {count_x[15:0], switches_i};

    phase_accum test_osc (
        .fpga_clk_i (fpga_clk_i),
        .rst_n_i    (rst_n_i),
        .enable_i   (enable_pa_x),
        .k_val_i    (k_val_pa_x),
        .wave_o     (clk_pa_x)
    );

    freq_meter meter (
        .fpga_clk_i (fpga_clk_i),
        .rst_n_i    (rst_n_i),
        .wave_i     (clk_pa_x),    // Sampled as data
        .count_o    (count_x),
        .valid_o    (valid_x)
    );

    seven_seg_driver disp (
        .fpga_clk_i (fpga_clk_i),
        .rst_n_i    (rst_n_i),
        .value_i    (disp_val_x),
        .digit_o    (digit_o),
        .segment_o  (segment_o)
    );

    assign clk_pa_o     = clk_pa_x;
    assign freq_count_o = count_x;
    assign freq_valid_o = valid_x;

endmodule

//--- test/tb_clk_gen.sv
`timescale 1ns/1ps

// Free-running clock for the testbench
module tb_clk_gen #(
    parameter real PERIOD_NS = 4.0 // 250 MHz board clock
) (
    output logic clk_o
);

    initial begin
        clk_o = 1'b0; // Low at time zero, first rise at half period
    end

    always begin
        #(PERIOD_NS / 2.0);
        clk_o = ~clk_o;
    end

endmodule

//--- test/osc_test_tb.sv
`timescale 1ns/1ps

`include "osc_test_cfg.svh"

module osc_test_tb
    import osc_pkg::*;
    import disp_pkg::*;
();

    localparam int  RST_CYCLES  = 5;
    localparam real DRIVE_DLY   = 0.5;              // ns after the rising edge
    localparam int  GATE_CYCLES = `OSC_GATE_CYCLES;
    localparam int  NUM_WINDOWS = 9;                // First window plus 4 settings x 2
    localparam int  TIMEOUT_CYCLES = RST_CYCLES + (NUM_WINDOWS + 1) * GATE_CYCLES;

    logic                    fpga_clk;
    logic                    rst_n;
    logic [15:0]             switches;
    logic                    clk_pa;
    freq_count_t             freq_count;
    logic                    freq_valid;
    logic [`DISP_DIGITS-1:0] digit;
    segments_t               segment;

    integer      seed = 32'h10ad_909c;
    freq_count_t exp_count;          // k when enabled and 0 when off
    logic        window_clean;       // Window in progress saw one setting only
    int          post_cnt   = 0;     // Cycles since reset release
    logic        rst_seen   = 1'b0;  // At least one reset edge done
    int          off_cycles = 0;     // Consecutive cycles with switch 9 low
    int          scan_idx;
    int          cycle_cnt  = 0;

    tb_clk_gen #(.PERIOD_NS(4.0)) clk_gen (
        .clk_o (fpga_clk)
    );

    osc_test_top osc_test_top_i (
        .fpga_clk_i   (fpga_clk),
        .rst_n_i      (rst_n),
        .switches_i   (switches),
        .clk_pa_o     (clk_pa),
        .freq_count_o (freq_count),
        .freq_valid_o (freq_valid),
        .digit_o      (digit),
        .segment_o    (segment)
    );

    //////////////////////////////
    // Reference model
    //////////////////////////////

    always @(posedge fpga_clk) begin
        if (!rst_n) begin
            rst_seen <= 1'b1;
            post_cnt <= 0;
        end else begin
            post_cnt <= post_cnt + 1;
        end
        if (rst_n && !switches[9]) begin
            off_cycles <= off_cycles + 1;
        end else begin
            off_cycles <= 0;
        end
    end

    // Digit advances once per scan period
    assign scan_idx = (post_cnt / `DISP_SCAN_DIV) % `DISP_DIGITS;

    // Active-low gfedcba for each hex digit
    function automatic logic [6:0] glyph_low(input logic [3:0] nib);
        case (nib)
            4'h0:    return 7'h40;
            4'h1:    return 7'h79;
            4'h2:    return 7'h24;
            4'h3:    return 7'h30;
            4'h4:    return 7'h19;
            4'h5:    return 7'h12;
            4'h6:    return 7'h02;
            4'h7:    return 7'h78;
            4'h8:    return 7'h00;
            4'h9:    return 7'h10;
            4'ha:    return 7'h08;
            4'hb:    return 7'h03; // b
            4'hc:    return 7'h46;
            4'hd:    return 7'h21; // d
            4'he:    return 7'h06;
            default: return 7'h0e; // F
        endcase
    endfunction

    function automatic logic [7:0] expected_segments(input logic [31:0] value, input int idx);
        logic [3:0] nib;
        logic [7:0] seg;
        nib = 4'(value >> (4 * idx));
        seg = {1'b1, glyph_low(nib)};
        if (idx == 4) begin
            seg[7] = 1'b0; // Separator point
        end
        return seg;
    endfunction

    //////////////////////////////
    // Checks
    //////////////////////////////

    reset_state_chk: assert property (@(posedge fpga_clk)
        (rst_seen && (!rst_n || post_cnt == 0)) |-> (!freq_valid && freq_count == '0))
        else begin
            $display("ERROR %0t ns: meter not clear, valid %b count %0d", $time,
                     $sampled(freq_valid), $sampled(freq_count));
            abort_run();
        end

    reset_blank_chk: assert property (@(posedge fpga_clk) !rst_n |-> digit == '1)
        else begin
            $display("ERROR %0t ns: digits %b lit during reset", $time, $sampled(digit));
            abort_run();
        end

    strobe_chk: assert property (@(posedge fpga_clk)
        rst_n |-> freq_valid == (post_cnt != 0 && post_cnt % GATE_CYCLES == 0))
        else begin
            $display("ERROR %0t ns: valid %b at cycle %0d after reset", $time,
                     $sampled(freq_valid), $sampled(post_cnt));
            abort_run();
        end

    count_hold_chk: assert property (@(posedge fpga_clk)
        (rst_seen && rst_n && !freq_valid) |-> $stable(freq_count))
        else begin
            $display("ERROR %0t ns: count moved to %0d without strobe", $time,
                     $sampled(freq_count));
            abort_run();
        end

    freq_chk: assert property (@(posedge fpga_clk)
        (rst_n && freq_valid && window_clean) |-> freq_count == exp_count)
        else begin
            $display("ERROR %0t ns: measured %0d, expected %0d", $time,
                     $sampled(freq_count), $sampled(exp_count));
            abort_run();
        end

    osc_off_chk: assert property (@(posedge fpga_clk) off_cycles >= 2 |-> $stable(clk_pa))
        else begin
            $display("ERROR %0t ns: test wave toggled while disabled", $time);
            abort_run();
        end

    scan_chk: assert property (@(posedge fpga_clk)
        rst_n |-> ($countones(~digit) == 1 && digit == ~(8'b1 << scan_idx)))
        else begin
            $display("ERROR %0t ns: digits %b, expected digit %0d", $time,
                     $sampled(digit), $sampled(scan_idx));
            abort_run();
        end

    segment_chk: assert property (@(posedge fpga_clk)
        rst_n |-> segment == expected_segments({freq_count, switches}, scan_idx))
        else begin
            $display("ERROR %0t ns: segments %h on digit %0d", $time,
                     $sampled(segment), $sampled(scan_idx));
            abort_run();
        end

    //////////////////////////////
    // Stimulus
    //////////////////////////////

    task automatic abort_run();
        $display("TESTBENCH FAILED");
        $fatal(1, "Simulation stopped on first error");
    endtask

    always @(posedge fpga_clk) begin
        cycle_cnt <= cycle_cnt + 1;
        if (cycle_cnt >= TIMEOUT_CYCLES) begin
            $display("Timeout: test still running after %0d clock cycles", cycle_cnt);
            abort_run();
        end
    end

    task automatic pick_increment(output logic [8:0] k);
        k = 9'($random(seed) & 32'h1ff);
        if (k == '0) begin
            k = 9'd1; // Zero would stop the wave
        end
    endtask

    task automatic apply_switches(input logic enable, input logic [8:0] k);
        logic [5:0] upper;
        upper     = 6'($random(seed)); // Display-only bits
        switches  = {upper, enable, k};
        exp_count = enable ? freq_count_t'(k) : '0;
    endtask

    // Returns one cycle after the strobe so the checks see it with the old model
    task automatic wait_after_pulse();
        do begin
            @(posedge fpga_clk);
            #DRIVE_DLY;
        end while (freq_valid !== 1'b1);
        @(posedge fpga_clk);
        #DRIVE_DLY;
    endtask

    task automatic change_setting(input logic enable, input logic [8:0] k);
        apply_switches(enable, k);
        window_clean = 1'b0;
        $display("Switches %h, expecting %0d per window", switches, exp_count);
        wait_after_pulse(); // Mixed window
        window_clean = 1'b1;
        wait_after_pulse(); // Checked window
    endtask

    initial begin
        logic [8:0] k;
        rst_n = 1'b0;
        pick_increment(k);
        apply_switches(1'b1, k);
        window_clean = 1'b1; // Accumulator starts from 0 with this k
        repeat (RST_CYCLES) @(posedge fpga_clk);
        #DRIVE_DLY;
        rst_n = 1'b1;
        $display("Switches %h, expecting %0d per window", switches, exp_count);
        wait_after_pulse();

        pick_increment(k);
        change_setting(1'b1, k);
        change_setting(1'b1, 9'd511); // Fastest wave
        pick_increment(k);
        change_setting(1'b0, k);      // Oscillator off
        pick_increment(k);
        change_setting(1'b1, k);      // Back on

        $display("TESTBENCH PASSED");
        $finish;
    end

endmodule

//--- verilog.f
+incdir+verilog
verilog/osc_pkg.sv
verilog/disp_pkg.sv
verilog/phase_accum.sv
verilog/freq_meter.sv
verilog/seven_seg_driver.sv
verilog/osc_test_top.sv
test/tb_clk_gen.sv
test/osc_test_tb.sv
